/* common/icache_macros.svh */
// cache geometry and RV32 field macros included by the icache package and every icache module
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// cache geometry
`define ICACHE_TAG_WIDTH 4
`define ICACHE_ENTRIES 64
`define ICACHE_BLOCK_WORDS 4
`define ICACHE_LINES (`ICACHE_ENTRIES / `ICACHE_BLOCK_WORDS)

// derived address widths for the word address {tag, index, offset}
`define ICACHE_PC_WIDTH (`ICACHE_TAG_WIDTH + $clog2(`ICACHE_ENTRIES))
`define ICACHE_INDEX_WIDTH ($clog2(`ICACHE_LINES))
`define ICACHE_OFFSET_WIDTH ($clog2(`ICACHE_BLOCK_WORDS))

// RV32 instruction word and opcode field
`define ICACHE_XLEN 32
`define ICACHE_OPCODE_WIDTH 7
`define ICACHE_OP_BRANCH 7'b1100011
`define ICACHE_OP_JAL 7'b1101111
`define ICACHE_OP_JALR 7'b1100111

// immediate widths without the sign bit
`define ICACHE_BIMM_WIDTH 12
`define ICACHE_JIMM_WIDTH 20

// immediate extract and inject where bit 0 of the value is always zero
`define ICACHE_BIMM_EXTRACT(i) {i[31], i[7], i[30:25], i[11:8], 1'b0}
`define ICACHE_JIMM_EXTRACT(i) {i[31], i[19:12], i[20], i[30:21], 1'b0}
`define ICACHE_BIMM_INJECT(i, v) {v[12], v[10:5], i[24:12], v[4:1], v[11], i[6:0]}
`define ICACHE_JIMM_INJECT(i, v) {v[20], v[10:1], v[11], v[19:12], i[11:0]}

`endif

/* common/icache_pkg.sv */
// shared vector types for the icache blocks, imported by each module header
`default_nettype none

`include "icache_macros.svh"

package icache_pkg;

  // one RV32 instruction word
  typedef logic [`ICACHE_XLEN-1:0] instr_t;

  // word address as seen by the fetch stage
  typedef logic [`ICACHE_PC_WIDTH-1:0] pc_t;

  // upper pc bits stored next to each line
  typedef logic [`ICACHE_TAG_WIDTH-1:0] tag_t;

  // line array address
  typedef logic [`ICACHE_INDEX_WIDTH-1:0] line_idx_t;

  // word position inside a line
  typedef logic [`ICACHE_OFFSET_WIDTH-1:0] blk_off_t;

  // low byte-address part of a branch target, imm width plus sign
  typedef logic [`ICACHE_BIMM_WIDTH:0] br_low_t;

  // low byte-address part of a jal target
  typedef logic [`ICACHE_JIMM_WIDTH:0] jal_low_t;

endpackage

`default_nettype wire

/* design/icache_fetch_top.sv */
// fetch-stage instruction cache, top level joining pre-decode, line store and target resolve
`default_nettype none

`include "icache_macros.svh"

module icache_fetch_top
  import icache_pkg::*;
(
  input  logic   clk_i,
  input  logic   network_reset_i,
  input  logic   v_i,
  input  logic   w_i,
  input  logic   flush_i,
  input  logic   read_pc_plus4_i,
  input  pc_t    w_pc_i,
  input  instr_t w_instr_i,
  input  pc_t    pc_i,
  input  pc_t    jalr_prediction_i,
  output instr_t instr_o,
  output pc_t    pred_or_jump_addr_o,
  output pc_t    pc_r_o,
  output logic   icache_miss_o,
  output logic   icache_flush_r_o
);

  // refill path
  instr_t inj_instr;
  logic   imm_sign;
  logic   low_cout;

  // latched line towards the result stage
  instr_t [`ICACHE_BLOCK_WORDS-1:0] line_instr;
  logic [`ICACHE_BLOCK_WORDS-1:0]   line_sign;
  logic [`ICACHE_BLOCK_WORDS-1:0]   line_cout;
  tag_t                             line_tag;
  pc_t                              pc_r;

  icache_predecode i_predecode (
    .w_pc_i      (w_pc_i),
    .w_instr_i   (w_instr_i),
    .inj_instr_o (inj_instr),
    .imm_sign_o  (imm_sign),
    .low_cout_o  (low_cout)
  );

  icache_line_store i_line_store (
    .clk_i            (clk_i),
    .network_reset_i  (network_reset_i),
    .v_i              (v_i),
    .w_i              (w_i),
    .flush_i          (flush_i),
    .read_pc_plus4_i  (read_pc_plus4_i),
    .w_pc_i           (w_pc_i),
    .pc_i             (pc_i),
    .inj_instr_i      (inj_instr),
    .imm_sign_i       (imm_sign),
    .low_cout_i       (low_cout),
    .line_instr_o     (line_instr),
    .line_sign_o      (line_sign),
    .line_cout_o      (line_cout),
    .line_tag_o       (line_tag),
    .pc_r_o           (pc_r),
    .icache_flush_r_o (icache_flush_r_o)
  );

  icache_target_resolve i_target_resolve (
    .pc_r_i              (pc_r),
    .line_instr_i        (line_instr),
    .line_sign_i         (line_sign),
    .line_cout_i         (line_cout),
    .line_tag_i          (line_tag),
    .jalr_prediction_i   (jalr_prediction_i),
    .instr_o             (instr_o),
    .pred_or_jump_addr_o (pred_or_jump_addr_o),
    .icache_miss_o       (icache_miss_o)
  );

  assign pc_r_o = pc_r;

endmodule

`default_nettype wire

/* icache/icache_line_store.sv */
// refill gather buffer, single-port line array and fetch pc register of the icache
`default_nettype none

`include "icache_macros.svh"

module icache_line_store
  import icache_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             network_reset_i,
  input  logic                             v_i,
  input  logic                             w_i,
  input  logic                             flush_i,
  input  logic                             read_pc_plus4_i,
  input  pc_t                              w_pc_i,
  input  pc_t                              pc_i,
  input  instr_t                           inj_instr_i,
  input  logic                             imm_sign_i,
  input  logic                             low_cout_i,
  output instr_t [`ICACHE_BLOCK_WORDS-1:0] line_instr_o,
  output logic [`ICACHE_BLOCK_WORDS-1:0]   line_sign_o,
  output logic [`ICACHE_BLOCK_WORDS-1:0]   line_cout_o,
  output tag_t                             line_tag_o,
  output pc_t                              pc_r_o,
  output logic                             icache_flush_r_o
);

  // line array
  instr_t [`ICACHE_BLOCK_WORDS-1:0] instr_mem [`ICACHE_LINES];
  logic [`ICACHE_BLOCK_WORDS-1:0]   sign_mem [`ICACHE_LINES];
  logic [`ICACHE_BLOCK_WORDS-1:0]   cout_mem [`ICACHE_LINES];
  tag_t                             tag_mem [`ICACHE_LINES];

  // words 0 to N-2 of the line being refilled
  instr_t [`ICACHE_BLOCK_WORDS-2:0] buf_instr_r;
  logic [`ICACHE_BLOCK_WORDS-2:0]   buf_sign_r;
  logic [`ICACHE_BLOCK_WORDS-2:0]   buf_cout_r;

  blk_off_t  write_cnt_r;
  pc_t       pc_r;
  logic      flush_r;
  logic      last_word;
  logic      buf_we;
  logic      mem_we;
  logic      mem_re;
  line_idx_t w_idx;
  line_idx_t r_idx;
  line_idx_t mem_addr;
  tag_t      w_tag;

  assign w_idx = w_pc_i[`ICACHE_OFFSET_WIDTH +: `ICACHE_INDEX_WIDTH];
  assign w_tag = w_pc_i[`ICACHE_OFFSET_WIDTH + `ICACHE_INDEX_WIDTH +: `ICACHE_TAG_WIDTH];
  assign r_idx = pc_i[`ICACHE_OFFSET_WIDTH +: `ICACHE_INDEX_WIDTH];

  // single port, refill index wins on writes
  assign mem_addr = w_i ? w_idx : r_idx;

  assign last_word = write_cnt_r == blk_off_t'(`ICACHE_BLOCK_WORDS - 1);
  assign buf_we    = v_i & w_i & ~last_word;
  assign mem_we    = v_i & w_i & last_word;

  // skip the read when moving sequentially off an even word
  assign mem_re = v_i & ~w_i & (pc_r[0] | ~read_pc_plus4_i);

  // refill word counter, wraps at the end of a line
  always_ff @(posedge clk_i) begin
    if (network_reset_i) begin
      write_cnt_r <= '0;
    end else if (v_i & w_i) begin
      write_cnt_r <= write_cnt_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (buf_we) begin
      buf_instr_r[write_cnt_r] <= inj_instr_i;
      buf_sign_r[write_cnt_r]  <= imm_sign_i;
      buf_cout_r[write_cnt_r]  <= low_cout_i;
    end
  end

  // array access, output holds the last line read
  always_ff @(posedge clk_i) begin
    if (mem_we) begin
      instr_mem[mem_addr] <= {inj_instr_i, buf_instr_r};
      sign_mem[mem_addr]  <= {imm_sign_i, buf_sign_r};
      cout_mem[mem_addr]  <= {low_cout_i, buf_cout_r};
      tag_mem[mem_addr]   <= w_tag;
    end else if (mem_re) begin
      line_instr_o <= instr_mem[mem_addr];
      line_sign_o  <= sign_mem[mem_addr];
      line_cout_o  <= cout_mem[mem_addr];
      line_tag_o   <= tag_mem[mem_addr];
    end
  end

  // fetch pc and flush flag, flush cleared by every read
  always_ff @(posedge clk_i) begin
    if (network_reset_i) begin
      pc_r    <= '0;
      flush_r <= 1'b0;
    end else if (v_i & ~w_i) begin
      pc_r    <= pc_i;
      flush_r <= 1'b0;
    end else begin
      flush_r <= flush_i;
    end
  end

  assign pc_r_o           = pc_r;
  assign icache_flush_r_o = flush_r;

endmodule

`default_nettype wire

/* icache/icache_predecode.sv */
// refill-side pre-decoder, folds the low pc bits into branch and jal immediates before storage
`default_nettype none

`include "icache_macros.svh"

module icache_predecode
  import icache_pkg::*;
(
  input  pc_t    w_pc_i,
  input  instr_t w_instr_i,
  output instr_t inj_instr_o,
  output logic   imm_sign_o,
  output logic   low_cout_o
);

  localparam int BR_LW = `ICACHE_BIMM_WIDTH + 1;
  localparam int JAL_LW = `ICACHE_JIMM_WIDTH + 1;

  logic                     is_branch;
  logic                     is_jal;
  logic [`ICACHE_XLEN-1:0]  pc_byte;
  br_low_t                  br_imm;
  br_low_t                  br_pc;
  br_low_t                  br_sum;
  logic                     br_cout;
  jal_low_t                 jal_imm;
  jal_low_t                 jal_pc;
  jal_low_t                 jal_sum;
  logic                     jal_cout;

  assign is_branch = w_instr_i[`ICACHE_OPCODE_WIDTH-1:0] == `ICACHE_OP_BRANCH;
  assign is_jal    = w_instr_i[`ICACHE_OPCODE_WIDTH-1:0] == `ICACHE_OP_JAL;

  // byte address, zero extended so either low part can be cut from it
  assign pc_byte = {{(`ICACHE_XLEN - `ICACHE_PC_WIDTH - 2){1'b0}}, w_pc_i, 2'b00};

  assign br_imm  = `ICACHE_BIMM_EXTRACT(w_instr_i);
  assign jal_imm = `ICACHE_JIMM_EXTRACT(w_instr_i);
  assign br_pc   = pc_byte[BR_LW-1:0];
  assign jal_pc  = pc_byte[JAL_LW-1:0];

  // partial target adders, carry goes to the result stage
  assign {br_cout, br_sum}   = {1'b0, br_imm} + {1'b0, br_pc};
  assign {jal_cout, jal_sum} = {1'b0, jal_imm} + {1'b0, jal_pc};

  // sum bit 0 is always zero and is dropped by the inject
  always_comb begin
    if (is_branch) begin
      inj_instr_o = `ICACHE_BIMM_INJECT(w_instr_i, br_sum);
    end else if (is_jal) begin
      inj_instr_o = `ICACHE_JIMM_INJECT(w_instr_i, jal_sum);
    end else begin
      inj_instr_o = w_instr_i;
    end
  end

  // non-control words carry the jal view, never consumed on read
  assign imm_sign_o = is_branch ? br_imm[`ICACHE_BIMM_WIDTH] : jal_imm[`ICACHE_JIMM_WIDTH];
  assign low_cout_o = is_branch ? br_cout : jal_cout;

endmodule

`default_nettype wire

/* icache/icache_target_resolve.sv */
// read result stage, picks the fetched word and completes the predicted jump target
`default_nettype none

`include "icache_macros.svh"

module icache_target_resolve
  import icache_pkg::*;
(
  input  pc_t                              pc_r_i,
  input  instr_t [`ICACHE_BLOCK_WORDS-1:0] line_instr_i,
  input  logic [`ICACHE_BLOCK_WORDS-1:0]   line_sign_i,
  input  logic [`ICACHE_BLOCK_WORDS-1:0]   line_cout_i,
  input  tag_t                             line_tag_i,
  input  pc_t                              jalr_prediction_i,
  output instr_t                           instr_o,
  output pc_t                              pred_or_jump_addr_o,
  output logic                             icache_miss_o
);

  localparam int BR_LW = `ICACHE_BIMM_WIDTH + 1;
  localparam int JAL_LW = `ICACHE_JIMM_WIDTH + 1;

  blk_off_t                       off;
  instr_t                         word;
  logic                           sign;
  logic                           cout;
  logic                           sel_keep;
  logic                           sel_inc;
  logic [`ICACHE_XLEN-1:0]        pc_byte;
  logic [`ICACHE_XLEN-BR_LW-1:0]  br_hi;
  logic [`ICACHE_XLEN-JAL_LW-1:0] jal_hi;
  logic [`ICACHE_XLEN-BR_LW-1:0]  br_hi_adj;
  logic [`ICACHE_XLEN-JAL_LW-1:0] jal_hi_adj;
  logic [`ICACHE_XLEN-1:0]        br_target;
  logic [`ICACHE_XLEN-1:0]        jal_target;
  logic [`ICACHE_OPCODE_WIDTH-1:0] opcode;

  assign off    = pc_r_i[`ICACHE_OFFSET_WIDTH-1:0];
  assign word   = line_instr_i[off];
  assign sign   = line_sign_i[off];
  assign cout   = line_cout_i[off];
  assign opcode = word[`ICACHE_OPCODE_WIDTH-1:0];

  // high target part comes from the registered pc
  assign pc_byte = {{(`ICACHE_XLEN - `ICACHE_PC_WIDTH - 2){1'b0}}, pc_r_i, 2'b00};
  assign br_hi   = pc_byte[`ICACHE_XLEN-1:BR_LW];
  assign jal_hi  = pc_byte[`ICACHE_XLEN-1:JAL_LW];

  // high part moves by -sign + carry
  assign sel_keep = ~(sign ^ cout);
  assign sel_inc  = ~sign & cout;

  always_comb begin
    if (sel_keep) begin
      br_hi_adj  = br_hi;
      jal_hi_adj = jal_hi;
    end else if (sel_inc) begin
      br_hi_adj  = br_hi + 1'b1;
      jal_hi_adj = jal_hi + 1'b1;
    end else begin
      br_hi_adj  = br_hi - 1'b1;
      jal_hi_adj = jal_hi - 1'b1;
    end
  end

  // full byte targets
  assign br_target  = {br_hi_adj, `ICACHE_BIMM_EXTRACT(word)};
  assign jal_target = {jal_hi_adj, `ICACHE_JIMM_EXTRACT(word)};

  always_comb begin
    if (opcode == `ICACHE_OP_JAL) begin
      pred_or_jump_addr_o = jal_target[2 +: `ICACHE_PC_WIDTH];
    end else if (opcode == `ICACHE_OP_JALR) begin
      pred_or_jump_addr_o = jalr_prediction_i;
    end else begin
      pred_or_jump_addr_o = br_target[2 +: `ICACHE_PC_WIDTH];
    end
  end

  assign instr_o = word;

  assign icache_miss_o =
    line_tag_i != pc_r_i[`ICACHE_OFFSET_WIDTH + `ICACHE_INDEX_WIDTH +: `ICACHE_TAG_WIDTH];

endmodule

`default_nettype wire

/* icache_fetch.f */
+incdir+common
common/icache_pkg.sv
icache/icache_predecode.sv
icache/icache_line_store.sv
icache/icache_target_resolve.sv
design/icache_fetch_top.sv
tests/tb_clock_gen.sv
tests/icache_fetch_assert.sv
tests/icache_fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the icache fetch testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module icache_fetch_tb \
  -f icache_fetch.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

sim_out=$(./obj_dir/Vicache_fetch_tb 2>&1)
status=$?
echo "$sim_out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

/* tests/icache_fetch_assert.sv */
// concurrent checks on refill ordering and reset state, bound into every icache_line_store
`default_nettype none

`include "icache_macros.svh"

module icache_fetch_assert
  import icache_pkg::*;
(
  input logic     clk_i,
  input logic     network_reset_i,
  input logic     v_i,
  input logic     w_i,
  input pc_t      w_pc_i,
  input blk_off_t write_cnt_i,
  input pc_t      pc_r_o,
  input logic     icache_flush_r_o
);

  // refill words come in offset order, so the pc offset tracks the counter
  write_order: assert property (
    @(posedge clk_i) disable iff (network_reset_i)
    (v_i && w_i) |-> (w_pc_i[`ICACHE_OFFSET_WIDTH-1:0] == write_cnt_i)
  ) else $error("refill word offset differs from the write counter");

  reset_pc: assert property (@(posedge clk_i) network_reset_i |=> (pc_r_o == '0))
    else $error("fetch pc register not cleared by reset");

  reset_flush: assert property (@(posedge clk_i) network_reset_i |=> !icache_flush_r_o)
    else $error("flush flag set after reset");

  reset_count: assert property (@(posedge clk_i) network_reset_i |=> (write_cnt_i == '0))
    else $error("write counter not cleared by reset");

endmodule

bind icache_line_store icache_fetch_assert i_line_store_assert (
  .clk_i            (clk_i),
  .network_reset_i  (network_reset_i),
  .v_i              (v_i),
  .w_i              (w_i),
  .w_pc_i           (w_pc_i),
  .write_cnt_i      (write_cnt_r),
  .pc_r_o           (pc_r_o),
  .icache_flush_r_o (icache_flush_r_o)
);

`default_nettype wire

/* tests/icache_fetch_tb.sv */
// testbench for the fetch icache that refills random lines and checks reads against a model
`default_nettype none

`include "icache_macros.svh"

module icache_fetch_tb
  import icache_pkg::*;
;

  localparam int BW = `ICACHE_BLOCK_WORDS;
  localparam int WADDR_W = `ICACHE_INDEX_WIDTH + `ICACHE_OFFSET_WIDTH;
  localparam int NUM_LINES = 12;
  localparam int MISS_READS = 8;
  localparam int PLUS4_PAIRS = 8;
  localparam int FLUSH_CYCLES = 3;
  localparam int PLANNED_CYCLES = 16 + NUM_LINES * (BW + 1) + NUM_LINES * BW * 2
                                  + MISS_READS * 2 + PLUS4_PAIRS * 4 + FLUSH_CYCLES + 4;
  localparam int CYCLE_LIMIT = 2 * PLANNED_CYCLES;

  localparam logic [1:0] KIND_PLAIN = 2'd0;
  localparam logic [1:0] KIND_BRANCH = 2'd1;
  localparam logic [1:0] KIND_JAL = 2'd2;
  localparam logic [1:0] KIND_JALR = 2'd3;

  logic   clk;
  logic   network_reset_i;
  logic   v_i;
  logic   w_i;
  logic   flush_i;
  logic   read_pc_plus4_i;
  pc_t    w_pc_i;
  instr_t w_instr_i;
  pc_t    pc_i;
  pc_t    jalr_prediction_i;
  instr_t instr_o;
  pc_t    pred_or_jump_addr_o;
  pc_t    pc_r_o;
  logic   icache_miss_o;
  logic   icache_flush_r_o;

  // reference model indexed by {line index, offset}
  instr_t     exp_instr [`ICACHE_ENTRIES];
  pc_t        exp_pred [`ICACHE_ENTRIES];
  logic [1:0] exp_kind [`ICACHE_ENTRIES];
  tag_t       line_tag_m [`ICACHE_LINES];

  integer seed;
  int     n_checks;
  int     n_errors;
  int     cycle_cnt = 0;

  tb_clock_gen i_clock_gen (
    .clk_o (clk)
  );

  icache_fetch_top i_dut (
    .clk_i               (clk),
    .network_reset_i     (network_reset_i),
    .v_i                 (v_i),
    .w_i                 (w_i),
    .flush_i             (flush_i),
    .read_pc_plus4_i     (read_pc_plus4_i),
    .w_pc_i              (w_pc_i),
    .w_instr_i           (w_instr_i),
    .pc_i                (pc_i),
    .jalr_prediction_i   (jalr_prediction_i),
    .instr_o             (instr_o),
    .pred_or_jump_addr_o (pred_or_jump_addr_o),
    .pc_r_o              (pc_r_o),
    .icache_miss_o       (icache_miss_o),
    .icache_flush_r_o    (icache_flush_r_o)
  );

  // B-type immediate scattered over the word
  function automatic instr_t set_br_imm(input instr_t i, input logic [12:0] v);
    instr_t o;
    o = i;
    o[31] = v[12];
    o[30:25] = v[10:5];
    o[11:8] = v[4:1];
    o[7] = v[11];
    return o;
  endfunction

  // J-type immediate
  function automatic instr_t set_jal_imm(input instr_t i, input logic [20:0] v);
    instr_t o;
    o = i;
    o[31] = v[20];
    o[30:21] = v[10:1];
    o[20] = v[11];
    o[19:12] = v[19:12];
    return o;
  endfunction

  task automatic make_word(input pc_t pc, output instr_t orig, output instr_t inj,
                           output pc_t pred, output logic [1:0] kind);
    logic [31:0] r;
    logic [31:0] imm;
    logic [31:0] sum;
    r = $random(seed);
    kind = r[1:0];
    orig = $random(seed);
    inj = orig;
    pred = '0;
    case (kind)
      KIND_BRANCH: begin
        imm = {{19{r[13]}}, r[13:2], 1'b0};
        orig[6:0] = `ICACHE_OP_BRANCH;
        orig = set_br_imm(orig, imm[12:0]);
        sum = (32'(pc) << 2) + imm;
        inj = set_br_imm(orig, sum[12:0]);
        pred = sum[`ICACHE_PC_WIDTH+1:2];
      end
      KIND_JAL: begin
        // short jumps so that carry cases show up too
        if (r[31]) begin
          imm = {{11{r[23]}}, r[23:4], 1'b0};
        end else begin
          imm = {{19{r[15]}}, r[15:4], 1'b0};
        end
        orig[6:0] = `ICACHE_OP_JAL;
        orig = set_jal_imm(orig, imm[20:0]);
        sum = (32'(pc) << 2) + imm;
        inj = set_jal_imm(orig, sum[20:0]);
        pred = sum[`ICACHE_PC_WIDTH+1:2];
      end
      KIND_JALR: begin
        orig[6:0] = `ICACHE_OP_JALR;
        inj = orig;
      end
      KIND_PLAIN: begin
        if (orig[6:0] == `ICACHE_OP_BRANCH || orig[6:0] == `ICACHE_OP_JAL ||
            orig[6:0] == `ICACHE_OP_JALR) begin
          orig[6:0] = 7'b0010011;
        end
        inj = orig;
      end
    endcase
  endtask

  task automatic refill_line(input line_idx_t idx, input tag_t tag);
    pc_t        pc;
    instr_t     orig;
    instr_t     inj;
    pc_t        pred;
    logic [1:0] kind;
    for (int i = 0; i < BW; i++) begin
      pc = {tag, idx, blk_off_t'(i)};
      make_word(pc, orig, inj, pred, kind);
      exp_instr[pc[WADDR_W-1:0]] = inj;
      exp_pred[pc[WADDR_W-1:0]] = pred;
      exp_kind[pc[WADDR_W-1:0]] = kind;
      @(posedge clk);
      #1;
      v_i = 1'b1;
      w_i = 1'b1;
      w_pc_i = pc;
      w_instr_i = orig;
    end
    @(posedge clk);
    #1;
    v_i = 1'b0;
    w_i = 1'b0;
    line_tag_m[idx] = tag;
  endtask

  // one read followed by a fresh jalr prediction in the result cycle
  task automatic read_word(input pc_t pc, input logic plus4);
    logic [31:0] r;
    @(posedge clk);
    #1;
    v_i = 1'b1;
    w_i = 1'b0;
    pc_i = pc;
    read_pc_plus4_i = plus4;
    @(posedge clk);
    #1;
    r = $random(seed);
    v_i = 1'b0;
    read_pc_plus4_i = 1'b0;
    jalr_prediction_i = r[`ICACHE_PC_WIDTH-1:0];
    #1;
  endtask

  task automatic check_hit(input pc_t pc);
    logic [WADDR_W-1:0] a;
    a = pc[WADDR_W-1:0];
    n_checks++;
    if (pc_r_o !== pc) begin
      n_errors++;
      $display("FAILED %0t: pc_r_o is %h, expected %h", $time, pc_r_o, pc);
    end
    if (icache_miss_o !== 1'b0) begin
      n_errors++;
      $display("FAILED %0t: miss raised for filled pc %h", $time, pc);
    end
    if (instr_o !== exp_instr[a]) begin
      n_errors++;
      $display("FAILED %0t: instr_o at pc %h is %h, expected %h", $time, pc, instr_o,
               exp_instr[a]);
    end
    if ((exp_kind[a] == KIND_BRANCH || exp_kind[a] == KIND_JAL) &&
        pred_or_jump_addr_o !== exp_pred[a]) begin
      n_errors++;
      $display("FAILED %0t: target at pc %h is %h, expected %h", $time, pc,
               pred_or_jump_addr_o, exp_pred[a]);
    end
    if (exp_kind[a] == KIND_JALR && pred_or_jump_addr_o !== jalr_prediction_i) begin
      n_errors++;
      $display("FAILED %0t: jalr target at pc %h is %h, expected %h", $time, pc,
               pred_or_jump_addr_o, jalr_prediction_i);
    end
  endtask

  initial begin
    line_idx_t   idx;
    tag_t        delta;
    blk_off_t    off;
    pc_t         pc;
    logic [31:0] r;
    seed = 32'h8279;
    n_checks = 0;
    n_errors = 0;
    network_reset_i = 1'b1;
    v_i = 1'b0;
    w_i = 1'b0;
    flush_i = 1'b0;
    read_pc_plus4_i = 1'b0;
    w_pc_i = '0;
    w_instr_i = '0;
    pc_i = '0;
    jalr_prediction_i = '0;
    repeat (16) @(posedge clk);
    #1;
    network_reset_i = 1'b0;
    n_checks++;
    if (pc_r_o !== '0 || icache_flush_r_o !== 1'b0) begin
      n_errors++;
      $display("FAILED %0t: pc_r_o %h flush %b after reset", $time, pc_r_o, icache_flush_r_o);
    end

    for (int n = 0; n < NUM_LINES; n++) begin
      r = $random(seed);
      refill_line(line_idx_t'(n), r[`ICACHE_TAG_WIDTH-1:0]);
    end

    // every refilled word once
    for (int n = 0; n < NUM_LINES; n++) begin
      for (int i = 0; i < BW; i++) begin
        pc = {line_tag_m[n], line_idx_t'(n), blk_off_t'(i)};
        read_word(pc, 1'b0);
        check_hit(pc);
      end
    end

    // sequential reads off an even word reuse the latched line
    for (int n = 0; n < PLUS4_PAIRS; n++) begin
      r = $random(seed);
      idx = line_idx_t'(r[7:0] % NUM_LINES);
      off = {r[8], 1'b0};
      pc = {line_tag_m[idx], idx, off};
      read_word(pc, 1'b0);
      check_hit(pc);
      pc = pc + 1'b1;
      read_word(pc, 1'b1);
      check_hit(pc);
    end

    for (int n = 0; n < MISS_READS; n++) begin
      r = $random(seed);
      idx = line_idx_t'(r[7:0] % NUM_LINES);
      delta = r[11:8];
      if (delta == '0) begin
        delta = 1;
      end
      off = r[13:12];
      pc = {line_tag_m[idx] ^ delta, idx, off};
      read_word(pc, 1'b0);
      n_checks++;
      if (pc_r_o !== pc) begin
        n_errors++;
        $display("FAILED %0t: pc_r_o is %h, expected %h", $time, pc_r_o, pc);
      end
      if (icache_miss_o !== 1'b1) begin
        n_errors++;
        $display("FAILED %0t: no miss for pc %h with foreign tag", $time, pc);
      end
    end

    // flush flag follows idle cycles and the next read clears it
    @(posedge clk);
    #1;
    flush_i = 1'b1;
    repeat (FLUSH_CYCLES) @(posedge clk);
    #1;
    n_checks++;
    if (icache_flush_r_o !== 1'b1) begin
      n_errors++;
      $display("FAILED %0t: flush flag low after idle flush cycles", $time);
    end
    pc = {line_tag_m[0], line_idx_t'(0), blk_off_t'(1)};
    read_word(pc, 1'b0);
    if (icache_flush_r_o !== 1'b0) begin
      n_errors++;
      $display("FAILED %0t: flush flag still high after a read", $time);
    end
    check_hit(pc);
    @(posedge clk);
    #1;
    flush_i = 1'b0;

    $display("checks %0d errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout, run stopped after %0d cycles", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
// free-running testbench clock with a period of 4 time units, instanced by the icache testbench
`default_nettype none

module tb_clock_gen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always begin
    #2;
    clk_o = ~clk_o;
  end

endmodule

`default_nettype wire
